//--- Bender.yml
package:
  name: slapfight_video

sources:
  - hw/video_pkg.sv
  - hw/video_regs_axil.sv
  - hw/raster_counter.sv
  - hw/line_phase_fsm.sv
  - hw/colour_mixer.sv
  - hw/slapfight_video.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tb_slapfight_video.sv

//--- hw/colour_mixer.sv
// layer priority and colour lookup
// foreground over sprites over background, then a host written
// 256 entry palette, two register stages from pixel in to rgb out

`timescale 1ns/10ps

module colour_mixer
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  colour_idx_t fg_pix_i,
	input  colour_idx_t sp_pix_i,
	input  colour_idx_t bg_pix_i,
	input  logic        pal_we_i,
	input  colour_idx_t pal_addr_i,
	input  rgb12_t      pal_data_i,
	output rgb12_t      rgb_o
);

	colour_idx_t win_idx;
	colour_idx_t idx_q;
	rgb12_t      pal_mem [256];

	// ============================================================
	// stage 1, priority select
	// ============================================================
	always_comb begin
		if ((fg_pix_i & FG_OPAQUE_MASK) != '0)
			win_idx = fg_pix_i;
		else if ((sp_pix_i & SP_OPAQUE_MASK) != '0)
			win_idx = sp_pix_i;
		else
			win_idx = bg_pix_i;  // background is never transparent
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			idx_q <= '0;
		else
			idx_q <= win_idx;
	end

	// ============================================================
	// stage 2, palette lookup
	// ============================================================
	always_ff @(posedge pixel_clk) begin
		if (pal_we_i)
			pal_mem[pal_addr_i] <= pal_data_i;
	end

	// read before write on a same entry collision
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n)
			rgb_o <= '0;
		else
			rgb_o <= pal_mem[idx_q];
	end

	a_pal_addr_known: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		pal_we_i |-> !$isunknown(pal_addr_i));

endmodule

//--- hw/line_phase_fsm.sv
// raster phase FSMs
// horizontal and vertical ACTIVE/FRONT/SYNC/BACK state machines,
// wrap pulses for the counters, registered sync and blank

`timescale 1ns/10ps

module line_phase_fsm
	import video_pkg::*;
#(
	parameter int unsigned H_ACTIVE = 256,
	parameter int unsigned H_FRONT  = 16,
	parameter int unsigned H_SYNC   = 32,
	parameter int unsigned H_BACK   = 80,
	parameter int unsigned V_ACTIVE = 224,
	parameter int unsigned V_FRONT  = 16,
	parameter int unsigned V_SYNC   = 8,
	parameter int unsigned V_BACK   = 16
) (
	input  logic    pixel_clk,
	input  logic    RESET_n,
	input  hcount_t hcount_i,
	input  vcount_t vcount_i,
	output logic    line_wrap_o,
	output logic    frame_wrap_o,
	output logic    hsync_o,
	output logic    vsync_o,
	output logic    hblank_o,
	output logic    vblank_o
);

	localparam hcount_t H_LAST = hcount_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam vcount_t V_LAST = vcount_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

	phase_e h_state;
	phase_e v_state;

	// advance when the count sits on the last cycle of the current phase
	function automatic phase_e next_phase(phase_e cur, int unsigned cnt, int unsigned act,
		int unsigned fp, int unsigned sy, int unsigned bk);
		phase_e nxt;
		nxt = cur;
		case (cur)
			ACTIVE:  if (cnt == act - 1) nxt = FRONT;
			FRONT:   if (cnt == act + fp - 1) nxt = SYNC;
			SYNC:    if (cnt == act + fp + sy - 1) nxt = BACK;
			BACK:    if (cnt == act + fp + sy + bk - 1) nxt = ACTIVE;
			default: nxt = ACTIVE;
		endcase
		return nxt;
	endfunction

	assign line_wrap_o  = (hcount_i == H_LAST);
	assign frame_wrap_o = line_wrap_o && (vcount_i == V_LAST);

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			h_state <= ACTIVE;
			v_state <= ACTIVE;
		end else begin
			h_state <= next_phase(h_state, hcount_i, H_ACTIVE, H_FRONT, H_SYNC, H_BACK);
			if (line_wrap_o)  // vertical steps once per line
				v_state <= next_phase(v_state, vcount_i, V_ACTIVE, V_FRONT, V_SYNC, V_BACK);
		end
	end

	// one cycle late to line up with the registered coordinates
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			hblank_o <= 1'b0;
			vblank_o <= 1'b0;
		end else begin
			hsync_o  <= (h_state == SYNC);
			vsync_o  <= (v_state == SYNC);
			hblank_o <= (h_state != ACTIVE);
			vblank_o <= (v_state != ACTIVE);
		end
	end

	a_hsync_in_hblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		hsync_o |-> hblank_o);
	a_vsync_in_vblank: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		vsync_o |-> vblank_o);

endmodule

//--- hw/raster_counter.sv
// beam position counters
// steps on the wrap pulses from the phase FSM, then registers the
// foreground and background layer coordinates with flip and scroll

`timescale 1ns/10ps

module raster_counter
	import video_pkg::*;
(
	input  logic     pixel_clk,
	input  logic     RESET_n,
	input  logic     line_wrap_i,
	input  logic     frame_wrap_i,
	input  logic     flip_i,
	input  coord_x_t scroll_x_i,
	input  coord_y_t scroll_y_i,
	output hcount_t  hcount_o,
	output vcount_t  vcount_o,
	output coord_x_t fg_x_o,
	output coord_y_t fg_y_o,
	output coord_x_t bg_x_o,
	output coord_y_t bg_y_o
);

	hcount_t  hcount_q;
	vcount_t  vcount_q;
	coord_x_t fg_x_d;
	coord_y_t fg_y_d;

	assign hcount_o = hcount_q;
	assign vcount_o = vcount_q;

	// ============================================================
	// beam counters
	// ============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			hcount_q <= '0;
			vcount_q <= '0;
		end else if (line_wrap_i) begin
			hcount_q <= '0;
			if (frame_wrap_i)
				vcount_q <= '0;
			else
				vcount_q <= vcount_q + 1'b1;
		end else begin
			hcount_q <= hcount_q + 1'b1;
		end
	end

	// flip inverts both axes over their own width
	assign fg_x_d = flip_i ? ~hcount_q : hcount_q;
	assign fg_y_d = flip_i ? ~vcount_q[7:0] : vcount_q[7:0];

	// coordinates lag the count by one cycle
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			fg_x_o <= '0;
			fg_y_o <= '0;
			bg_x_o <= '0;
			bg_y_o <= '0;
		end else begin
			fg_x_o <= fg_x_d;
			fg_y_o <= fg_y_d;
			bg_x_o <= fg_x_d + scroll_x_i;  // wraps at 512
			bg_y_o <= fg_y_d + scroll_y_i;  // wraps at 256
		end
	end

endmodule

//--- hw/slapfight_video.sv
// raster timing and colour output, top level
// host registers, phase FSMs, beam counters and colour mixer

`timescale 1ns/10ps

module slapfight_video
	import video_pkg::*;
#(
	parameter int unsigned H_ACTIVE = 256,
	parameter int unsigned H_FRONT  = 16,
	parameter int unsigned H_SYNC   = 32,
	parameter int unsigned H_BACK   = 80,
	parameter int unsigned V_ACTIVE = 224,
	parameter int unsigned V_FRONT  = 16,
	parameter int unsigned V_SYNC   = 8,
	parameter int unsigned V_BACK   = 16
) (
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  axil_addr_t  s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  axil_data_t  s_wdata_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output axil_resp_t  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  axil_addr_t  s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output axil_data_t  s_rdata_o,
	output axil_resp_t  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,
	input  colour_idx_t fg_pix_i,
	input  colour_idx_t sp_pix_i,
	input  colour_idx_t bg_pix_i,
	output coord_x_t    fg_x_o,
	output coord_y_t    fg_y_o,
	output coord_x_t    bg_x_o,
	output coord_y_t    bg_y_o,
	output logic        hsync_o,
	output logic        vsync_o,
	output logic        hblank_o,
	output logic        vblank_o,
	output rgb12_t      rgb_o
);

	coord_x_t    scroll_x;
	coord_y_t    scroll_y;
	logic        flip;
	logic        pal_we;
	colour_idx_t pal_addr;
	rgb12_t      pal_data;
	hcount_t     hcount;
	vcount_t     vcount;
	logic        line_wrap;
	logic        frame_wrap;

	video_regs_axil u_video_regs_axil (
		.pixel_clk   (pixel_clk),
		.RESET_n     (RESET_n),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.scroll_x_o  (scroll_x),
		.scroll_y_o  (scroll_y),
		.flip_o      (flip),
		.pal_we_o    (pal_we),
		.pal_addr_o  (pal_addr),
		.pal_data_o  (pal_data)
	);

	line_phase_fsm #(
		.H_ACTIVE (H_ACTIVE),
		.H_FRONT  (H_FRONT),
		.H_SYNC   (H_SYNC),
		.H_BACK   (H_BACK),
		.V_ACTIVE (V_ACTIVE),
		.V_FRONT  (V_FRONT),
		.V_SYNC   (V_SYNC),
		.V_BACK   (V_BACK)
	) u_line_phase_fsm (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.hcount_i     (hcount),
		.vcount_i     (vcount),
		.line_wrap_o  (line_wrap),
		.frame_wrap_o (frame_wrap),
		.hsync_o      (hsync_o),
		.vsync_o      (vsync_o),
		.hblank_o     (hblank_o),
		.vblank_o     (vblank_o)
	);

	raster_counter u_raster_counter (
		.pixel_clk    (pixel_clk),
		.RESET_n      (RESET_n),
		.line_wrap_i  (line_wrap),
		.frame_wrap_i (frame_wrap),
		.flip_i       (flip),
		.scroll_x_i   (scroll_x),
		.scroll_y_i   (scroll_y),
		.hcount_o     (hcount),
		.vcount_o     (vcount),
		.fg_x_o       (fg_x_o),
		.fg_y_o       (fg_y_o),
		.bg_x_o       (bg_x_o),
		.bg_y_o       (bg_y_o)
	);

	colour_mixer u_colour_mixer (
		.pixel_clk  (pixel_clk),
		.RESET_n    (RESET_n),
		.fg_pix_i   (fg_pix_i),
		.sp_pix_i   (sp_pix_i),
		.bg_pix_i   (bg_pix_i),
		.pal_we_i   (pal_we),
		.pal_addr_i (pal_addr),
		.pal_data_i (pal_data),
		.rgb_o      (rgb_o)
	);

endmodule

//--- hw/video_pkg.sv
// video package
// shared widths, FSM phases, host register map and layer masks
// for the raster timing and colour output block

package video_pkg;

	// ============================================================
	// widths that carry a meaning
	// ============================================================
	typedef logic [8:0]  hcount_t;      // horizontal beam count
	typedef logic [8:0]  vcount_t;      // vertical beam count
	typedef logic [8:0]  coord_x_t;     // layer x, wraps at 512
	typedef logic [7:0]  coord_y_t;     // layer y, wraps at 256
	typedef logic [7:0]  colour_idx_t;  // layer pixel and palette address
	typedef logic [11:0] rgb12_t;       // {r, g, b} 4 bits each
	typedef logic [11:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0]  axil_resp_t;

	// raster phase, same encoding for both axes
	typedef enum logic [1:0] {
		ACTIVE,
		FRONT,
		SYNC,
		BACK
	} phase_e;

	// ============================================================
	// host register map
	// ============================================================
	localparam axil_addr_t REG_SCROLL_X = 12'h000;
	localparam axil_addr_t REG_SCROLL_Y = 12'h004;
	localparam axil_addr_t REG_CONTROL  = 12'h008;  // bit 0 flip
	localparam axil_addr_t PAL_BASE     = 12'h400;  // 256 words up to 0x7fc
	localparam axil_addr_t PAL_WIN_MASK = 12'hc00;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	// a layer pixel is transparent when these bits are all zero
	localparam colour_idx_t FG_OPAQUE_MASK = 8'h03;
	localparam colour_idx_t SP_OPAQUE_MASK = 8'h0f;

endpackage

//--- hw/video_regs_axil.sv
// host register block
// AXI4-Lite slave with one transaction in flight, holds scroll and
// flip, turns palette window writes into single-cycle RAM writes

`timescale 1ns/10ps

module video_regs_axil
	import video_pkg::*;
(
	input  logic        pixel_clk,
	input  logic        RESET_n,
	input  axil_addr_t  s_awaddr_i,
	input  logic        s_awvalid_i,
	output logic        s_awready_o,
	input  axil_data_t  s_wdata_i,
	input  logic        s_wvalid_i,
	output logic        s_wready_o,
	output axil_resp_t  s_bresp_o,
	output logic        s_bvalid_o,
	input  logic        s_bready_i,
	input  axil_addr_t  s_araddr_i,
	input  logic        s_arvalid_i,
	output logic        s_arready_o,
	output axil_data_t  s_rdata_o,
	output axil_resp_t  s_rresp_o,
	output logic        s_rvalid_o,
	input  logic        s_rready_i,
	output coord_x_t    scroll_x_o,
	output coord_y_t    scroll_y_o,
	output logic        flip_o,
	output logic        pal_we_o,
	output colour_idx_t pal_addr_o,
	output rgb12_t      pal_data_o
);

	logic       resp_pending;
	logic       wr_accept;
	logic       rd_accept;
	logic       aw_is_pal;
	logic       aw_is_reg;
	logic       rd_ok;
	axil_data_t rd_data;

	assign resp_pending = s_bvalid_o | s_rvalid_o;
	assign wr_accept    = s_awvalid_i & s_wvalid_i & ~resp_pending;
	assign rd_accept    = s_arvalid_i & ~resp_pending & ~wr_accept;  // write wins a tie

	assign s_awready_o = wr_accept;
	assign s_wready_o  = wr_accept;
	assign s_arready_o = rd_accept;

	assign aw_is_pal = (s_awaddr_i & PAL_WIN_MASK) == PAL_BASE;
	assign aw_is_reg = (s_awaddr_i == REG_SCROLL_X) || (s_awaddr_i == REG_SCROLL_Y) ||
		(s_awaddr_i == REG_CONTROL);

	// ============================================================
	// write side
	// ============================================================
	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			s_bvalid_o <= 1'b0;
			s_bresp_o  <= RESP_OKAY;
			scroll_x_o <= '0;
			scroll_y_o <= '0;
			flip_o     <= 1'b0;
			pal_we_o   <= 1'b0;
		end else begin
			pal_we_o <= 1'b0;
			if (wr_accept) begin
				s_bvalid_o <= 1'b1;
				s_bresp_o  <= (aw_is_reg | aw_is_pal) ? RESP_OKAY : RESP_SLVERR;
				pal_we_o   <= aw_is_pal;  // rises with bvalid
				case (s_awaddr_i)
					REG_SCROLL_X: scroll_x_o <= coord_x_t'(s_wdata_i);
					REG_SCROLL_Y: scroll_y_o <= coord_y_t'(s_wdata_i);
					REG_CONTROL:  flip_o     <= s_wdata_i[0];
					default: ;
				endcase
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (wr_accept && aw_is_pal) begin
			pal_addr_o <= s_awaddr_i[9:2];  // word index in window
			pal_data_o <= rgb12_t'(s_wdata_i);
		end
	end

	// ============================================================
	// read side
	// ============================================================
	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (s_araddr_i)
			REG_SCROLL_X: rd_data = axil_data_t'(scroll_x_o);
			REG_SCROLL_Y: rd_data = axil_data_t'(scroll_y_o);
			REG_CONTROL:  rd_data = axil_data_t'(flip_o);
			default:      rd_ok   = 1'b0;  // palette is write only
		endcase
	end

	always_ff @(posedge pixel_clk or negedge RESET_n) begin
		if (!RESET_n) begin
			s_rvalid_o <= 1'b0;
			s_rresp_o  <= RESP_OKAY;
			s_rdata_o  <= '0;
		end else if (rd_accept) begin
			s_rvalid_o <= 1'b1;
			s_rresp_o  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			s_rdata_o  <= rd_data;
		end else if (s_rready_i) begin
			s_rvalid_o <= 1'b0;
		end
	end

	// responses are held until the host takes them
	a_bvalid_hold: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o);
	a_rvalid_hold: assert property (@(posedge pixel_clk) disable iff (!RESET_n)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o);

endmodule

//--- slapfight_video.f
+incdir+include
hw/video_pkg.sv
hw/video_regs_axil.sv
hw/raster_counter.sv
hw/line_phase_fsm.sv
hw/colour_mixer.sv
hw/slapfight_video.sv
tb/tb_slapfight_video.sv

//--- include/tb_video_model.svh
// testbench reference model
// mirrors the host registers and the palette, applies the layer
// priority rule to give the expected colour index

`ifndef TB_VIDEO_MODEL_SVH
`define TB_VIDEO_MODEL_SVH

logic [11:0] m_pal [256];
logic [8:0]  m_sx;
logic [7:0]  m_sy;
logic        m_flip;
logic [7:0]  exp_idx_q [$];  // winning indices still in the pipeline

// returns the expected write response
function automatic logic [1:0] model_write(input logic [11:0] addr, input logic [31:0] data);
	logic [1:0] resp;
	resp = 2'b00;
	if (addr >= 12'h400 && addr <= 12'h7fc)
		m_pal[addr[9:2]] = data[11:0];  // one word per entry
	else if (addr == 12'h000)
		m_sx = data[8:0];
	else if (addr == 12'h004)
		m_sy = data[7:0];
	else if (addr == 12'h008)
		m_flip = data[0];
	else
		resp = 2'b10;  // slverr, nothing stored
	return resp;
endfunction

function automatic void model_read(input logic [11:0] addr, output logic [31:0] data,
	output logic [1:0] resp);
	data = '0;
	resp = 2'b00;
	case (addr)
		12'h000: data = {23'd0, m_sx};
		12'h004: data = {24'd0, m_sy};
		12'h008: data = {31'd0, m_flip};
		default: resp = 2'b10;  // palette window reads too
	endcase
endfunction

// foreground over sprites over background
function automatic logic [7:0] win_index(input logic [7:0] fg, input logic [7:0] sp,
	input logic [7:0] bg);
	if (fg[1:0] != 2'b00)
		return fg;
	if (sp[3:0] != 4'h0)
		return sp;
	return bg;
endfunction

`endif

//--- tb/tb_slapfight_video.sv
// testbench for the raster timing and colour output block
// random host traffic with back-pressure, per cycle raster and
// coordinate checks, colour path against a reference model

`timescale 1ns/10ps

module tb_slapfight_video
	import video_pkg::*;
;

	localparam int unsigned H_ACTIVE = 32;
	localparam int unsigned H_FRONT  = 4;
	localparam int unsigned H_SYNC   = 4;
	localparam int unsigned H_BACK   = 8;
	localparam int unsigned V_ACTIVE = 12;
	localparam int unsigned V_FRONT  = 2;
	localparam int unsigned V_SYNC   = 2;
	localparam int unsigned V_BACK   = 4;
	localparam int unsigned H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int unsigned V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int unsigned FRAME_CYC = H_TOTAL * V_TOTAL;
	localparam int unsigned N_FRAMES  = 3;
	localparam int unsigned N_AXI     = 400;  // upper bound on bus transactions
	localparam int unsigned AXI_CYC   = 40;   // worst case per transaction
	localparam int unsigned CLK_NS    = 4;
	localparam int unsigned WATCHDOG_NS =
		(N_FRAMES * FRAME_CYC + N_AXI * AXI_CYC + 2000) * CLK_NS;

	logic        pixel_clk;
	logic        RESET_n;
	axil_addr_t  s_awaddr_i, s_araddr_i;
	axil_data_t  s_wdata_i, s_rdata_o;
	logic        s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o;
	axil_resp_t  s_bresp_o, s_rresp_o;
	logic        s_bvalid_o, s_bready_i, s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;
	colour_idx_t fg_pix_i, sp_pix_i, bg_pix_i;
	coord_x_t    fg_x_o, bg_x_o;
	coord_y_t    fg_y_o, bg_y_o;
	logic        hsync_o, vsync_o, hblank_o, vblank_o;
	rgb12_t      rgb_o;
	logic        colour_on;
	int          errors;
	int          checks;

	`include "tb_video_model.svh"

	slapfight_video #(
		.H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
		.V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
	) u_slapfight_video (.*);

	initial begin
		pixel_clk = 1'b0;
		forever #(CLK_NS / 2) pixel_clk = ~pixel_clk;
	end

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// holds ready low for random stretches, valid must stay up meanwhile
	task automatic take_response(input bit is_read);
		logic done;
		done = 1'b0;
		if (is_read)
			s_rready_i = ($urandom % 3 == 0);
		else
			s_bready_i = ($urandom % 3 == 0);
		@(negedge pixel_clk);
		while (!done) begin
			if ((is_read ? s_rvalid_o : s_bvalid_o) !== 1'b1) begin
				errors++;
				$display("response valid went low before the host took it at %0t", $time);
				done = 1'b1;
			end else if (is_read ? s_rready_i : s_bready_i) begin
				done = 1'b1;
			end else begin
				@(posedge pixel_clk);
				#1;
				if (is_read)
					s_rready_i = ($urandom % 3 == 0);
				else
					s_bready_i = ($urandom % 3 == 0);
				@(negedge pixel_clk);
			end
		end
	endtask

	task automatic axi_write(input axil_addr_t addr, input axil_data_t data);
		axil_resp_t exp_resp;
		s_awaddr_i  = addr;
		s_wdata_i   = data;
		s_awvalid_i = 1'b1;
		s_wvalid_i  = 1'b1;
		@(negedge pixel_clk);
		while (!s_awready_o) begin
			@(posedge pixel_clk);
			#1;
			@(negedge pixel_clk);
		end
		check_hex("s_wready_o", s_wready_o, 1'b1);
		@(posedge pixel_clk);
		#1;
		s_awvalid_i = 1'b0;
		s_wvalid_i  = 1'b0;
		exp_resp = model_write(addr, data);  // takes effect with the accepting edge
		take_response(1'b0);
		check_hex("s_bresp_o", s_bresp_o, exp_resp);
		@(posedge pixel_clk);
		#1;
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read_check(input axil_addr_t addr);
		axil_data_t exp_data;
		axil_resp_t exp_resp;
		s_araddr_i  = addr;
		s_arvalid_i = 1'b1;
		@(negedge pixel_clk);
		while (!s_arready_o) begin
			@(posedge pixel_clk);
			#1;
			@(negedge pixel_clk);
		end
		@(posedge pixel_clk);
		#1;
		s_arvalid_i = 1'b0;
		model_read(addr, exp_data, exp_resp);
		take_response(1'b1);
		check_hex("s_rdata_o", s_rdata_o, exp_data);
		check_hex("s_rresp_o", s_rresp_o, exp_resp);
		@(posedge pixel_clk);
		#1;
		s_rready_i = 1'b0;
	endtask

	// half the time the opaque bits are cleared so lower layers show
	task automatic drive_pixels();
		fg_pix_i = colour_idx_t'($urandom);
		sp_pix_i = colour_idx_t'($urandom);
		bg_pix_i = colour_idx_t'($urandom);
		if ($urandom % 2)
			fg_pix_i[1:0] = 2'b00;
		if ($urandom % 2)
			sp_pix_i[3:0] = 4'h0;
	endtask

	// ============================================================
	// per cycle monitor, outputs at a negedge describe beam pos (mh, mv)
	// ============================================================
	initial begin : monitor
		int unsigned mh;
		int unsigned mv;
		coord_x_t    exp_fx, dx, sx_d;
		coord_y_t    exp_fy, dy, sy_d;
		logic        flip_d;
		colour_idx_t idx;
		mh = 0;
		mv = 0;
		sx_d = '0;
		sy_d = '0;
		flip_d = 1'b0;
		@(posedge RESET_n);
		@(posedge pixel_clk);
		forever begin
			@(negedge pixel_clk);
			check_hex("hblank_o", hblank_o, mh >= H_ACTIVE);
			check_hex("hsync_o", hsync_o,
				(mh >= H_ACTIVE + H_FRONT) && (mh < H_ACTIVE + H_FRONT + H_SYNC));
			check_hex("vblank_o", vblank_o, mv >= V_ACTIVE);
			check_hex("vsync_o", vsync_o,
				(mv >= V_ACTIVE + V_FRONT) && (mv < V_ACTIVE + V_FRONT + V_SYNC));
			exp_fx = flip_d ? ~coord_x_t'(mh) : coord_x_t'(mh);
			exp_fy = flip_d ? ~coord_y_t'(mv) : coord_y_t'(mv);
			dx = bg_x_o - fg_x_o;  // modulo 512
			dy = bg_y_o - fg_y_o;
			check_hex("fg_x_o", fg_x_o, exp_fx);
			check_hex("fg_y_o", fg_y_o, exp_fy);
			check_hex("bg_x_o - fg_x_o", dx, sx_d);
			check_hex("bg_y_o - fg_y_o", dy, sy_d);
			sx_d = m_sx;  // register writes show one cycle later
			sy_d = m_sy;
			flip_d = m_flip;
			if (colour_on) begin
				exp_idx_q.push_back(win_index(fg_pix_i, sp_pix_i, bg_pix_i));
				if (exp_idx_q.size() > 2) begin
					idx = exp_idx_q.pop_front();
					check_hex("rgb_o", rgb_o, m_pal[idx]);
				end
			end else begin
				exp_idx_q.delete();
			end
			mh = mh + 1;
			if (mh == H_TOTAL) begin
				mh = 0;
				mv = (mv + 1 == V_TOTAL) ? 0 : mv + 1;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout, the run did not end within %0d ns", WATCHDOG_NS);
		$display("Regression failed");
		$finish;
	end

	// ============================================================
	// test sequence
	// ============================================================
	initial begin : main_seq
		int unsigned seed_val;
		axil_addr_t  addr;
		int          n;
		seed_val = $urandom(32'hda1e46c4);
		errors = 0;
		checks = 0;
		colour_on = 1'b0;
		m_sx = '0;
		m_sy = '0;
		m_flip = 1'b0;
		RESET_n = 1'b0;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		fg_pix_i = '0;
		sp_pix_i = '0;
		bg_pix_i = '0;
		repeat (2) @(posedge pixel_clk);
		@(negedge pixel_clk);
		check_hex("hsync_o", hsync_o, 1'b0);  // reset values
		check_hex("vsync_o", vsync_o, 1'b0);
		check_hex("s_bvalid_o", s_bvalid_o, 1'b0);
		check_hex("s_rvalid_o", s_rvalid_o, 1'b0);
		check_hex("rgb_o", rgb_o, 12'h000);
		@(posedge pixel_clk);
		#1;
		RESET_n = 1'b1;

		// scroll and control registers
		repeat (24) begin
			addr = axil_addr_t'($urandom_range(2, 0) * 4);
			axi_write(addr, $urandom);
			axi_read_check(axil_addr_t'($urandom_range(2, 0) * 4));
		end
		// unmapped space and palette reads give slverr
		axi_write(12'h00c, $urandom);
		axi_read_check(12'h00c);
		repeat (8) begin
			addr = 12'h800 | axil_addr_t'($urandom & 32'h7fc);
			axi_write(addr, $urandom);
			axi_read_check(addr);
			axi_read_check(PAL_BASE + axil_addr_t'($urandom_range(255, 0) * 4));
		end
		axi_read_check(REG_SCROLL_X);
		axi_read_check(REG_SCROLL_Y);
		axi_read_check(REG_CONTROL);

		// fill the whole palette, then overwrite a few entries
		for (n = 0; n < 256; n++)
			axi_write(PAL_BASE + axil_addr_t'(n * 4), $urandom);
		repeat (16)
			axi_write(PAL_BASE + axil_addr_t'($urandom_range(255, 0) * 4), $urandom);

		// colour path, one frame per flip setting
		colour_on = 1'b1;
		for (n = 0; n < N_FRAMES; n++) begin
			axi_write(REG_CONTROL, n % 2);
			axi_write(REG_SCROLL_X, $urandom);
			axi_write(REG_SCROLL_Y, $urandom);
			repeat (FRAME_CYC) begin
				drive_pixels();
				@(posedge pixel_clk);
				#1;
			end
		end
		repeat (3) @(posedge pixel_clk);
		#1;
		colour_on = 1'b0;

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
